// File: filelist.f
logic/comm_pkg.sv
logic/comm_ifs.sv
logic/transfer_counter.sv
logic/host_link.sv
logic/mem_port.sv
logic/comm_sequencer.sv
logic/comm_controller.sv
testbench/comm_checker.sv
testbench/tb_comm_controller.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_comm_controller -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_comm_controller.sv
`default_nettype none

module tb_comm_controller;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_CMDS          = 10;
	localparam int CMD_CYCLES      = 600;
	localparam int SETTLE          = 20;
	localparam int PURGE           = int'(comm_pkg::PURGE_CYCLES);
	localparam int WATCHDOG_CYCLES = 2 * PURGE + N_CMDS * CMD_CYCLES + 2000;

	typedef enum logic [1:0] {CMD_WRITE, CMD_READ, CMD_DEVICE, CMD_BAD} cmd_kind_e;

	typedef struct packed {
		cmd_kind_e   kind;
		logic        multi;
		logic [11:0] words;
		logic [31:0] addr;
		logic [2:0]  dev;
		logic [31:0] data;
		logic [11:0] replies;
	} cmd_t;

	typedef struct packed {
		logic        rw;
		logic [2:0]  dev;
		logic [31:0] add;
		logic [31:0] data;
	} mem_req_t;

	logic             clock_i = 1'b0;
	logic             resetn_i;
	logic             rx_empty_i;
	logic [31:0]      rx_data_i;
	logic             rx_read_o;
	logic             tx_full_i;
	logic             tx_write_o;
	logic [31:0]      tx_data_o;
	logic             ready_i;
	logic             done_i;
	logic [31:0]      data_i;
	logic             req_o;
	logic             rw_o;
	logic [2:0]       reqdev_o;
	logic [31:0]      add_o;
	logic [31:0]      data_o;
	logic             clear_o;
	logic             exception_o;
	comm_pkg::state_e state_o;

	// fifo and memory models
	logic [31:0] rx_q[$];
	logic [31:0] tx_q[$];
	mem_req_t    req_q[$];
	logic [31:0] mem [256];
	logic [31:0] exp_mem [256];
	logic        mem_busy = 1'b0;
	int          done_wait = 0;

	cmd_t        cmds [N_CMDS];
	logic [31:0] rng_state = 32'd53747;
	int          cycle_count = 0;
	int          pop_count = 0;
	int          last_pop_cycle = 0;
	int          check_count = 0;
	int          error_count = 0;

	always #50 clock_i = ~clock_i;

	comm_controller u_dut (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.rx_empty_i  (rx_empty_i),
		.rx_data_i   (rx_data_i),
		.rx_read_o   (rx_read_o),
		.tx_full_i   (tx_full_i),
		.tx_write_o  (tx_write_o),
		.tx_data_o   (tx_data_o),
		.ready_i     (ready_i),
		.done_i      (done_i),
		.data_i      (data_i),
		.req_o       (req_o),
		.rw_o        (rw_o),
		.reqdev_o    (reqdev_o),
		.add_o       (add_o),
		.data_o      (data_o),
		.clear_o     (clear_o),
		.exception_o (exception_o),
		.state_o     (state_o)
	);

	bind comm_controller comm_checker u_checker (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.rx_empty_i  (rx_empty_i),
		.rx_read_o   (rx_read_o),
		.tx_full_i   (tx_full_i),
		.tx_write_o  (tx_write_o),
		.ready_i     (ready_i),
		.req_o       (req_o),
		.exception_o (exception_o)
	);

	// ------------------------------------------------------------------------
	// helpers
	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] word_index(logic [31:0] a);
		return a[9:2];
	endfunction

	// power-up contents, every word index gives a different value
	function automatic logic [31:0] fill_word(int idx);
		return 32'hA5C30000 ^ (32'(idx) * 32'h9E3779B1);
	endfunction

	function automatic logic [31:0] write_word(cmd_t c, int k);
		return c.data + 32'(k) * 32'h01000003;
	endfunction

	function automatic logic [31:0] cfg_word(cmd_t c);
		logic [31:0] w;
		w = '0;
		w[comm_pkg::CFG_WRITE_BIT]  = (c.kind == CMD_WRITE);
		w[comm_pkg::CFG_COUNT_BIT]  = c.multi;
		w[comm_pkg::CFG_DEVICE_BIT] = (c.kind == CMD_DEVICE);
		w[26:24] = c.dev;
		if (c.kind == CMD_DEVICE) begin
			w[1:0] = c.data[1:0];
		end else begin
			w[11:0] = c.words;
		end
		return w;
	endfunction

	function automatic cmd_t make_cmd(cmd_kind_e kind, logic multi, logic [11:0] words,
			logic [31:0] addr, logic [2:0] dev, logic [31:0] data, logic [11:0] replies);
		cmd_t c;
		c.kind    = kind;
		c.multi   = multi;
		c.words   = words;
		c.addr    = addr;
		c.dev     = dev;
		c.data    = data;
		c.replies = replies;
		return c;
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_error(string what);
		error_count++;
		$display("Error: %s", what);
	endtask

	// ------------------------------------------------------------------------
	// one clock of the fifo and memory models, inputs change 5 ns after the edge
	task automatic next_cycle();
		mem_req_t r;
		@(posedge clock_i);
		#5;
		cycle_count++;
		if (rx_read_o) begin
			if (rx_q.size() == 0) begin
				report_error("receive FIFO popped while empty");
			end else begin
				void'(rx_q.pop_front());
				pop_count++;
				last_pop_cycle = cycle_count;
			end
		end
		if (tx_write_o) begin
			if (tx_full_i) begin
				report_error("transmit FIFO written while full");
			end
			tx_q.push_back(tx_data_o);
		end
		if (clear_o) begin
			done_i = 1'b0;
			mem_busy = 1'b0;
		end
		if (req_o) begin
			if (mem_busy) begin
				report_error("memory request issued while another is in flight");
			end
			r.rw   = rw_o;
			r.dev  = reqdev_o;
			r.add  = add_o;
			r.data = data_o;
			req_q.push_back(r);
			if (rw_o) begin
				mem[word_index(add_o)] = data_o;
			end
			mem_busy = 1'b1;
			rng_state = xorshift32(rng_state);
			done_wait = int'(rng_state[2:0]);
		end else if (mem_busy && !done_i) begin
			if (done_wait == 0) begin
				done_i = 1'b1;
				data_i = mem[word_index(add_o)];
			end else begin
				done_wait--;
			end
		end
		rng_state = xorshift32(rng_state);
		ready_i = (rng_state[1:0] != 2'b00);
		tx_full_i = (rng_state[4:3] == 2'b00);
		rx_empty_i = (rx_q.size() == 0);
		rx_data_i = rx_empty_i ? 32'd0 : rx_q[0];
	endtask

	task automatic wait_replies(int n);
		while (tx_q.size() < n) begin
			next_cycle();
		end
	endtask

	task automatic wait_state(comm_pkg::state_e s);
		while (state_o != s) begin
			next_cycle();
		end
	endtask

	// ------------------------------------------------------------------------
	// one table entry: send it, wait for the replies, check both sides
	task automatic run_command(int i);
		cmd_t        c;
		mem_req_t    r;
		int          k;
		int          nreq;
		logic [31:0] a;
		c = cmds[i];
		tx_q.delete();
		req_q.delete();
		// without the count enable only one word moves, whatever the count field
		nreq = (c.kind == CMD_DEVICE || !c.multi) ? 1 : int'(c.words);
		if (c.kind == CMD_BAD) begin
			rx_q.push_back(c.data);
			rx_q.push_back(cfg_word(c));
			while (!exception_o) begin
				next_cycle();
			end
			repeat (SETTLE) begin
				next_cycle();
				check_value($sformatf("cmd %0d exception", i), 32'd1, 32'(exception_o));
			end
			check_value($sformatf("cmd %0d state", i), 32'(comm_pkg::ERROR), 32'(state_o));
			check_value($sformatf("cmd %0d words left", i), 32'd1, rx_q.size());
			check_value($sformatf("cmd %0d requests", i), 32'd0, req_q.size());
			check_value($sformatf("cmd %0d replies", i), 32'd0, tx_q.size());
		end else begin
			rx_q.push_back(32'd0);
			rx_q.push_back(cfg_word(c));
			if (c.kind != CMD_DEVICE) begin
				rx_q.push_back(c.addr);
			end
			if (c.kind == CMD_WRITE) begin
				for (k = 0; k < nreq; k++) begin
					rx_q.push_back(write_word(c, k));
					exp_mem[word_index(c.addr + 32'(4 * k))] = write_word(c, k);
				end
			end
			wait_replies(int'(c.replies));
			repeat (SETTLE) next_cycle();
			check_value($sformatf("cmd %0d replies", i), 32'(c.replies), tx_q.size());
			check_value($sformatf("cmd %0d requests", i), 32'(nreq), req_q.size());
			check_value($sformatf("cmd %0d words left", i), 32'd0, rx_q.size());
			check_value($sformatf("cmd %0d exception", i), 32'd0, 32'(exception_o));
			for (k = 0; k < nreq && k < req_q.size(); k++) begin
				r = req_q[k];
				a = c.addr + 32'(4 * k);
				if (c.kind == CMD_DEVICE) begin
					check_value($sformatf("cmd %0d device", i), 32'(c.dev), 32'(r.dev));
					check_value($sformatf("cmd %0d device rw", i), 32'd0, 32'(r.rw));
					check_value($sformatf("cmd %0d device data", i), 32'(c.data[1:0]),
						r.data);
				end else begin
					check_value($sformatf("cmd %0d req %0d rw", i, k),
						32'(c.kind == CMD_WRITE), 32'(r.rw));
					check_value($sformatf("cmd %0d req %0d dev", i, k), 32'd0, 32'(r.dev));
					check_value($sformatf("cmd %0d req %0d addr", i, k), a, r.add);
				end
				if (c.kind == CMD_WRITE) begin
					check_value($sformatf("cmd %0d req %0d data", i, k), write_word(c, k),
						r.data);
					check_value($sformatf("cmd %0d mem %0d", i, k), write_word(c, k),
						mem[word_index(a)]);
				end
				if (c.kind == CMD_READ && k < tx_q.size()) begin
					check_value($sformatf("cmd %0d read word %0d", i, k),
						exp_mem[word_index(a)], tx_q[k]);
				end
			end
			// write and device commands end with a single zero word
			if (c.kind != CMD_READ && tx_q.size() > 0) begin
				check_value($sformatf("cmd %0d ack", i), 32'd0, tx_q[0]);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	initial begin : main
		logic [31:0] sync_words [3];
		int          j;
		int          gap;
		resetn_i   = 1'b0;
		rx_empty_i = 1'b1;
		rx_data_i  = 32'd0;
		tx_full_i  = 1'b0;
		ready_i    = 1'b0;
		done_i     = 1'b0;
		data_i     = 32'd0;
		for (j = 0; j < 256; j++) begin
			mem[j] = fill_word(j);
			exp_mem[j] = fill_word(j);
		end
		cmds[0] = make_cmd(CMD_WRITE,  1'b1, 12'd4, 32'h100, 3'd0, 32'h11110000, 12'd1);
		cmds[1] = make_cmd(CMD_READ,   1'b1, 12'd4, 32'h100, 3'd0, 32'd0, 12'd4);
		cmds[2] = make_cmd(CMD_READ,   1'b1, 12'd6, 32'h204, 3'd0, 32'd0, 12'd6);
		cmds[3] = make_cmd(CMD_DEVICE, 1'b0, 12'd1, 32'h0, 3'd5, 32'h2, 12'd1);
		cmds[4] = make_cmd(CMD_WRITE,  1'b0, 12'd3, 32'h040, 3'd0, 32'hDEADBEEF, 12'd1);
		cmds[5] = make_cmd(CMD_READ,   1'b0, 12'd7, 32'h040, 3'd0, 32'd0, 12'd1);
		cmds[6] = make_cmd(CMD_WRITE,  1'b1, 12'd3, 32'h3F0, 3'd0, 32'h7700AA55, 12'd1);
		cmds[7] = make_cmd(CMD_READ,   1'b1, 12'd5, 32'h3E8, 3'd0, 32'd0, 12'd5);
		cmds[8] = make_cmd(CMD_DEVICE, 1'b0, 12'd1, 32'h0, 3'd2, 32'h1, 12'd1);
		cmds[9] = make_cmd(CMD_BAD,    1'b0, 12'd1, 32'h0, 3'd0, 32'h00000777, 12'd0);

		// stale words from before reset, all of them purged
		for (j = 0; j < 4; j++) begin
			rx_q.push_back(32'hBAD00000 + 32'(j));
		end
		repeat (3) next_cycle();
		resetn_i = 1'b1;
		while (rx_q.size() != 0) begin
			next_cycle();
		end
		repeat (100) next_cycle();
		rx_q.push_back(32'hBAD000FF);
		while (rx_q.size() != 0) begin
			next_cycle();
		end
		check_value("purge pops", 32'd5, pop_count);
		wait_state(comm_pkg::SYNC);
		gap = cycle_count - last_pop_cycle;
		if (gap < PURGE) begin
			report_error($sformatf("purge left after only %0d quiet cycles", gap));
		end
		check_value("replies during purge", 32'd0, tx_q.size());

		// sync exchange, the key word itself is not answered
		rng_state = xorshift32(rng_state);
		sync_words[0] = 32'h01234567;
		sync_words[1] = 32'hFFFF0000;
		sync_words[2] = rng_state;
		for (j = 0; j < 3; j++) begin
			rx_q.push_back(sync_words[j]);
		end
		rx_q.push_back(comm_pkg::SYNC_KEY);
		wait_replies(3);
		wait_state(comm_pkg::IDLE);
		repeat (SETTLE) next_cycle();
		check_value("sync replies", 32'd3, tx_q.size());
		for (j = 0; j < 3 && j < tx_q.size(); j++) begin
			check_value($sformatf("sync echo %0d", j), sync_words[j] ^ comm_pkg::SYNC_XOR,
				tx_q[j]);
		end

		for (j = 0; j < N_CMDS; j++) begin
			run_command(j);
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// bound from the purge length and the number of table entries
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock_i);
		$display("Timeout: no progress after %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/comm_checker.sv
`default_nettype none

module comm_checker (
	input logic clock_i,
	input logic resetn_i,
	input logic rx_empty_i,
	input logic rx_read_o,
	input logic tx_full_i,
	input logic tx_write_o,
	input logic ready_i,
	input logic req_o,
	input logic exception_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// memory request only after ready was seen
	a_req_after_ready: assert property (
		@(posedge clock_i) disable iff (!resetn_i) req_o |-> $past(ready_i)
	) else $error("req_o without ready_i in the previous cycle");

	a_pop_not_empty: assert property (
		@(posedge clock_i) disable iff (!resetn_i) rx_read_o |-> !$past(rx_empty_i)
	) else $error("rx_read_o while the receive FIFO was empty");

	a_push_not_full: assert property (
		@(posedge clock_i) disable iff (!resetn_i) tx_write_o |-> !$past(tx_full_i)
	) else $error("tx_write_o while the transmit FIFO was full");

	// sticky until reset
	a_exception_sticky: assert property (
		@(posedge clock_i) disable iff (!resetn_i) exception_o |=> exception_o
	) else $error("exception_o fell without a reset");

endmodule

`default_nettype wire

// File: logic/comm_controller.sv
`default_nettype none

module comm_controller (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	// receive fifo
	input  logic                        rx_empty_i,
	input  logic [comm_pkg::WORD_W-1:0] rx_data_i,
	output logic                        rx_read_o,
	// transmit fifo
	input  logic                        tx_full_i,
	output logic                        tx_write_o,
	output logic [comm_pkg::WORD_W-1:0] tx_data_o,
	// memory side
	input  logic                        ready_i,
	input  logic                        done_i,
	input  logic [comm_pkg::WORD_W-1:0] data_i,
	output logic                        req_o,
	output logic                        rw_o,
	output logic [comm_pkg::DEV_W-1:0]  reqdev_o,
	output logic [comm_pkg::ADDR_W-1:0] add_o,
	output logic [comm_pkg::WORD_W-1:0] data_o,
	output logic                        clear_o,
	// status
	output logic                        exception_o,
	output comm_pkg::state_e            state_o
);

	host_ctl_if host_bus ();
	mem_ctl_if  mem_bus ();

	comm_pkg::count_op_e         count_op;
	logic                        count_zero;
	logic                        count_last;
	logic [comm_pkg::WORD_W-1:0] rx_word;

	comm_sequencer u_sequencer (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.rx_empty_i   (rx_empty_i),
		.tx_full_i    (tx_full_i),
		.ready_i      (ready_i),
		.done_i       (done_i),
		.host         (host_bus.sequencer),
		.mem          (mem_bus.sequencer),
		.count_op_o   (count_op),
		.count_zero_i (count_zero),
		.count_last_i (count_last),
		.exception_o  (exception_o),
		.state_o      (state_o)
	);

	// word count comes straight from the config word decode
	transfer_counter u_counter (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.count_op_i   (count_op),
		.count_load_i (host_bus.rx_count),
		.zero_o       (count_zero),
		.last_o       (count_last)
	);

	host_link u_host_link (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.rx_data_i  (rx_data_i),
		.data_i     (data_i),
		.host       (host_bus.link),
		.rx_word_o  (rx_word),
		.rx_read_o  (rx_read_o),
		.tx_write_o (tx_write_o),
		.tx_data_o  (tx_data_o)
	);

	mem_port u_mem_port (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.rx_word_i (rx_word),
		.mem       (mem_bus.port),
		.req_o     (req_o),
		.rw_o      (rw_o),
		.reqdev_o  (reqdev_o),
		.add_o     (add_o),
		.data_o    (data_o),
		.clear_o   (clear_o)
	);

endmodule

`default_nettype wire

// File: logic/comm_sequencer.sv
`default_nettype none

module comm_sequencer (
	input  logic                clock_i,
	input  logic                resetn_i,
	input  logic                rx_empty_i,
	input  logic                tx_full_i,
	input  logic                ready_i,
	input  logic                done_i,
	host_ctl_if.sequencer       host,
	mem_ctl_if.sequencer        mem,
	output comm_pkg::count_op_e count_op_o,
	input  logic                count_zero_i,
	input  logic                count_last_i,
	output logic                exception_o,
	output comm_pkg::state_e    state_o
);

	comm_pkg::state_e state_q, state_d;

	// configured command
	logic is_write_q, is_write_d;
	logic is_dev_q, is_dev_d;
	logic multi_q, multi_d;
	logic load_addr_q, load_addr_d;

	logic rx_ok;
	logic tx_ok;
	logic word_last;

	// only one pop or push in flight, the fifo flags lag the strobe
	assign rx_ok = !rx_empty_i && !host.rx_pending;
	assign tx_ok = !tx_full_i && !host.tx_pending;

	// single word commands end after the first word
	assign word_last = !multi_q || count_zero_i || count_last_i;

	// address word sits in the rx register one cycle after its pop
	assign mem.load_addr = load_addr_q;
	assign state_o = state_q;

	// -------------------------------------------------------------------------
	// next state and strobes
	always_comb begin
		state_d         = state_q;
		is_write_d      = is_write_q;
		is_dev_d        = is_dev_q;
		multi_d         = multi_q;
		load_addr_d     = 1'b0;
		count_op_o      = comm_pkg::CNT_HOLD;
		host.pop        = 1'b0;
		host.push       = 1'b0;
		host.capture    = 1'b0;
		host.tx_src     = comm_pkg::TX_ACK;
		mem.step_addr   = 1'b0;
		mem.issue_dev   = 1'b0;
		mem.issue_read  = 1'b0;
		mem.issue_write = 1'b0;
		mem.clear       = 1'b0;

		case (state_q)
			comm_pkg::PURGE: begin
				// any word restarts the quiet period
				if (!rx_empty_i) begin
					count_op_o = comm_pkg::CNT_LOAD_PURGE;
					host.pop = !host.rx_pending;
				end else if (count_zero_i || count_last_i) begin
					state_d = comm_pkg::SYNC;
				end else begin
					count_op_o = comm_pkg::CNT_DEC;
				end
			end
			comm_pkg::SYNC: begin
				if (rx_ok && tx_ok) begin
					host.pop = 1'b1;
					if (host.rx_is_key) begin
						state_d = comm_pkg::IDLE;
					end else begin
						host.push = 1'b1;
						host.tx_src = comm_pkg::TX_ECHO;
					end
				end
			end
			comm_pkg::IDLE: begin
				if (rx_ok) begin
					host.pop = 1'b1;
					state_d = host.rx_is_zero ? comm_pkg::CONFIG : comm_pkg::ERROR;
				end
			end
			comm_pkg::CONFIG: begin
				if (rx_ok) begin
					host.pop = 1'b1;
					count_op_o = comm_pkg::CNT_LOAD_WORDS;
					is_write_d = host.rx_cfg_write;
					is_dev_d = host.rx_cfg_device;
					multi_d = host.rx_cfg_count_en;
					state_d = host.rx_cfg_device ? comm_pkg::WAIT_READY_WRITE
						: comm_pkg::GET_ADDR;
				end
			end
			comm_pkg::GET_ADDR: begin
				if (rx_ok) begin
					host.pop = 1'b1;
					load_addr_d = 1'b1;
					state_d = is_write_q ? comm_pkg::GET_WORD : comm_pkg::WAIT_READY_READ;
				end
			end
			comm_pkg::GET_WORD: begin
				if (rx_ok) begin
					host.pop = 1'b1;
					state_d = comm_pkg::WAIT_READY_WRITE;
				end
			end
			comm_pkg::WAIT_READY_WRITE: begin
				if (ready_i) begin
					mem.issue_dev = is_dev_q;
					mem.issue_write = !is_dev_q;
					state_d = comm_pkg::WAIT_DONE_WRITE;
				end
			end
			comm_pkg::WAIT_DONE_WRITE: begin
				if (done_i) begin
					mem.clear = 1'b1;
					if (is_dev_q || word_last) begin
						state_d = comm_pkg::ACK;
					end else begin
						count_op_o = comm_pkg::CNT_DEC;
						mem.step_addr = 1'b1;
						state_d = comm_pkg::GET_WORD;
					end
				end
			end
			comm_pkg::WAIT_READY_READ: begin
				if (ready_i) begin
					mem.issue_read = 1'b1;
					state_d = comm_pkg::WAIT_DONE_READ;
				end
			end
			comm_pkg::WAIT_DONE_READ: begin
				if (done_i) begin
					mem.clear = 1'b1;
					host.capture = 1'b1;
					state_d = comm_pkg::SEND_WORD;
				end
			end
			comm_pkg::SEND_WORD: begin
				if (tx_ok) begin
					host.push = 1'b1;
					host.tx_src = comm_pkg::TX_READ;
					if (word_last) begin
						state_d = comm_pkg::IDLE;
					end else begin
						count_op_o = comm_pkg::CNT_DEC;
						mem.step_addr = 1'b1;
						state_d = comm_pkg::WAIT_READY_READ;
					end
				end
			end
			comm_pkg::ACK: begin
				if (tx_ok) begin
					host.push = 1'b1;
					host.tx_src = comm_pkg::TX_ACK;
					state_d = comm_pkg::IDLE;
				end
			end
			// no way out of ERROR except reset
			default: state_d = comm_pkg::ERROR;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= comm_pkg::PURGE;
			is_write_q  <= 1'b0;
			is_dev_q    <= 1'b0;
			multi_q     <= 1'b0;
			load_addr_q <= 1'b0;
			exception_o <= 1'b0;
		end else begin
			state_q     <= state_d;
			is_write_q  <= is_write_d;
			is_dev_q    <= is_dev_d;
			multi_q     <= multi_d;
			load_addr_q <= load_addr_d;
			exception_o <= exception_o | (state_d == comm_pkg::ERROR);
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_port.sv
`default_nettype none

module mem_port (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic [comm_pkg::WORD_W-1:0] rx_word_i,
	mem_ctl_if.port                     mem,
	output logic                        req_o,
	output logic                        rw_o,
	output logic [comm_pkg::DEV_W-1:0]  reqdev_o,
	output logic [comm_pkg::ADDR_W-1:0] add_o,
	output logic [comm_pkg::WORD_W-1:0] data_o,
	output logic                        clear_o
);

	logic issue;

	assign issue = mem.issue_dev | mem.issue_read | mem.issue_write;

	// -------------------------------------------------------------------------
	// request and clear pulses
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			req_o    <= 1'b0;
			rw_o     <= 1'b0;
			reqdev_o <= '0;
			clear_o  <= 1'b0;
		end else begin
			req_o   <= issue;
			rw_o    <= mem.issue_write;
			clear_o <= mem.clear;
			// device number only travels with a device request
			if (mem.issue_dev) begin
				reqdev_o <= rx_word_i[comm_pkg::CFG_DEV_LSB +: comm_pkg::DEV_W];
			end else begin
				reqdev_o <= '0;
			end
		end
	end

	// -------------------------------------------------------------------------
	// address and write data, held until the next request
	always_ff @(posedge clock_i) begin
		if (mem.load_addr) begin
			add_o <= rx_word_i[comm_pkg::ADDR_W-1:0];
		end else if (mem.step_addr) begin
			add_o <= add_o + comm_pkg::WORD_STEP;
		end

		if (mem.issue_write) begin
			data_o <= rx_word_i;
		end else if (mem.issue_dev) begin
			data_o <= comm_pkg::WORD_W'(rx_word_i[comm_pkg::DEV_DATA_W-1:0]);
		end
	end

endmodule

`default_nettype wire

// File: logic/host_link.sv
`default_nettype none

module host_link (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic [comm_pkg::WORD_W-1:0] rx_data_i,
	input  logic [comm_pkg::WORD_W-1:0] data_i,
	host_ctl_if.link                    host,
	output logic [comm_pkg::WORD_W-1:0] rx_word_o,
	output logic                        rx_read_o,
	output logic                        tx_write_o,
	output logic [comm_pkg::WORD_W-1:0] tx_data_o
);

	logic [comm_pkg::WORD_W-1:0] read_q;

	// -------------------------------------------------------------------------
	// decode of the fifo head word
	assign host.rx_is_key       = (rx_data_i == comm_pkg::SYNC_KEY);
	assign host.rx_is_zero      = (rx_data_i == '0);
	assign host.rx_cfg_write    = rx_data_i[comm_pkg::CFG_WRITE_BIT];
	assign host.rx_cfg_count_en = rx_data_i[comm_pkg::CFG_COUNT_BIT];
	assign host.rx_cfg_device   = rx_data_i[comm_pkg::CFG_DEVICE_BIT];
	assign host.rx_count = comm_pkg::COUNT_W'(rx_data_i[comm_pkg::CFG_COUNT_W-1:0]);

	assign host.rx_pending = rx_read_o;
	assign host.tx_pending = tx_write_o;

	// fifo strobes, one word each
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			rx_read_o  <= 1'b0;
			tx_write_o <= 1'b0;
		end else begin
			rx_read_o  <= host.pop;
			tx_write_o <= host.push;
		end
	end

	// -------------------------------------------------------------------------
	// word registers
	always_ff @(posedge clock_i) begin
		if (host.pop) begin
			rx_word_o <= rx_data_i;
		end
		// read data taken on the clear edge
		if (host.capture) begin
			read_q <= data_i;
		end
		if (host.push) begin
			case (host.tx_src)
				comm_pkg::TX_ECHO: tx_data_o <= rx_data_i ^ comm_pkg::SYNC_XOR;
				comm_pkg::TX_READ: tx_data_o <= read_q;
				default:           tx_data_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/transfer_counter.sv
`default_nettype none

module transfer_counter (
	input  logic                         clock_i,
	input  logic                         resetn_i,
	input  comm_pkg::count_op_e          count_op_i,
	input  logic [comm_pkg::COUNT_W-1:0] count_load_i,
	output logic                         zero_o,
	output logic                         last_o
);

	logic [comm_pkg::COUNT_W-1:0] count_q;

	// -------------------------------------------------------------------------
	// countdown, starts full for the purge after reset
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			count_q <= comm_pkg::PURGE_CYCLES;
		end else begin
			case (count_op_i)
				comm_pkg::CNT_LOAD_PURGE: begin
					count_q <= comm_pkg::PURGE_CYCLES;
				end
				comm_pkg::CNT_LOAD_WORDS: begin
					count_q <= count_load_i;
				end
				comm_pkg::CNT_DEC: begin
					// saturate at zero
					if (count_q != '0) begin
						count_q <= count_q - 1'b1;
					end
				end
				default: begin
					count_q <= count_q;
				end
			endcase
		end
	end

	assign zero_o = (count_q == '0);
	assign last_o = (count_q == comm_pkg::COUNT_W'(1));

endmodule

`default_nettype wire

// File: logic/comm_ifs.sv
`default_nettype none

// sequencer <-> host link
interface host_ctl_if;
	logic                         pop;
	logic                         push;
	logic                         capture;
	comm_pkg::tx_src_e            tx_src;
	// strobes still in flight, fifo flags not yet updated
	logic                         rx_pending;
	logic                         tx_pending;
	// decode of the word at the head of the receive fifo
	logic                         rx_is_key;
	logic                         rx_is_zero;
	logic                         rx_cfg_write;
	logic                         rx_cfg_count_en;
	logic                         rx_cfg_device;
	logic [comm_pkg::COUNT_W-1:0] rx_count;

	modport sequencer (
		output pop, push, capture, tx_src,
		input  rx_pending, tx_pending, rx_is_key, rx_is_zero,
		input  rx_cfg_write, rx_cfg_count_en, rx_cfg_device
	);

	modport link (
		input  pop, push, capture, tx_src,
		output rx_pending, tx_pending, rx_is_key, rx_is_zero,
		output rx_cfg_write, rx_cfg_count_en, rx_cfg_device, rx_count
	);
endinterface

// sequencer <-> memory port
interface mem_ctl_if;
	logic load_addr;
	logic step_addr;
	logic issue_dev;
	logic issue_read;
	logic issue_write;
	logic clear;

	modport sequencer (output load_addr, step_addr, issue_dev, issue_read, issue_write, clear);
	modport port (input load_addr, step_addr, issue_dev, issue_read, issue_write, clear);
endinterface

`default_nettype wire

// File: logic/comm_pkg.sv
`default_nettype none

package comm_pkg;

	// -------------------------------------------------------------------------
	// widths
	localparam int unsigned WORD_W      = 32;
	localparam int unsigned ADDR_W      = 32;
	localparam int unsigned COUNT_W     = 15;
	localparam int unsigned DEV_W       = 3;
	localparam int unsigned DEV_DATA_W  = 2;
	localparam int unsigned CFG_COUNT_W = 12;

	// -------------------------------------------------------------------------
	// protocol constants
	localparam logic [COUNT_W-1:0] PURGE_CYCLES = 15'd20000;
	localparam logic [WORD_W-1:0]  SYNC_KEY     = 32'h4A78B9F2;
	localparam logic [WORD_W-1:0]  SYNC_XOR     = 32'hCD0031F7;
	localparam logic [ADDR_W-1:0]  WORD_STEP    = 32'd4;

	// configuration word fields
	localparam int unsigned CFG_WRITE_BIT  = 12;
	localparam int unsigned CFG_COUNT_BIT  = 13;
	localparam int unsigned CFG_DEVICE_BIT = 14;
	localparam int unsigned CFG_DEV_LSB    = 24;

	// -------------------------------------------------------------------------
	// sequencer states, also visible on state_o
	typedef enum logic [5:0] {
		PURGE,
		SYNC,
		IDLE,
		CONFIG,
		GET_ADDR,
		GET_WORD,
		WAIT_READY_WRITE,
		WAIT_DONE_WRITE,
		WAIT_READY_READ,
		WAIT_DONE_READ,
		SEND_WORD,
		ACK,
		ERROR
	} state_e;

	// transmit word source
	typedef enum logic [1:0] {TX_ECHO, TX_ACK, TX_READ} tx_src_e;

	// counter opcodes
	typedef enum logic [1:0] {CNT_HOLD, CNT_LOAD_PURGE, CNT_LOAD_WORDS, CNT_DEC} count_op_e;

endpackage

`default_nettype wire
